// File: Makefile
SRCS := $(filter-out +%,$(shell cat build.f)) logic/cft_config.svh

all: run

obj_dir/Vcft_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module cft_tb -f build.f

run: obj_dir/Vcft_tb
	obj_dir/Vcft_tb | tee sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: build.f
+incdir+logic
logic/cft_pkg.sv
logic/cft_stage_if.sv
logic/card_ctl.sv
logic/card_mem.sv
logic/card_alu.sv
logic/card_reg.sv
logic/cft_top.sv
tb/cft_clock.sv
tb/cft_checker.sv
tb/cft_tb.sv

// File: logic/card_alu.sv
////////////////////
// Execute card. AC and flags change only on an accepted instruction
////////////////////

`include "cft_config.svh"

module card_alu (
   input  logic     clk,
   input  logic     reset,
   cft_stage_if.snk opr,
   cft_stage_if.src exe
);

   cft_pkg::word_t             ac_q;      // Accumulator
   cft_pkg::flags_t            flags_q;
   cft_pkg::word_t             ac_d;
   cft_pkg::flags_t            flags_d;
   logic [`CFT_WORD_W:0]       sum;       // With carry out
   logic                       take;

   assign opr.ready = !exe.valid || exe.ready;
   assign take      = opr.valid && opr.ready;
   assign sum       = {1'b0, ac_q} + {1'b0, opr.operand};

   assign exe.ac    = ac_q;     // Held while stalled since take is low
   assign exe.flags = flags_q;
   assign exe.rd    = 1'b0;

   always_comb begin
      ac_d    = ac_q;
      flags_d = flags_q;        // L and V kept by default
      case (opr.op)
         cft_pkg::OP_LOAD, cft_pkg::OP_LI: ac_d = opr.operand;
         cft_pkg::OP_ADD, cft_pkg::OP_ADDI: begin
            ac_d       = sum[`CFT_WORD_W-1:0];
            flags_d.fl = sum[`CFT_WORD_W];
            flags_d.fv = (ac_q[`CFT_WORD_W-1] == opr.operand[`CFT_WORD_W-1]) &&
                         (sum[`CFT_WORD_W-1] != ac_q[`CFT_WORD_W-1]);
         end
         cft_pkg::OP_AND: ac_d = ac_q & opr.operand;
         cft_pkg::OP_OR:  ac_d = ac_q | opr.operand;
         cft_pkg::OP_XOR: ac_d = ac_q ^ opr.operand;
         default:         ac_d = ac_q;  // STORE and NOP
      endcase
      flags_d.fz = (ac_d == '0);          // Z and N track the new AC
      flags_d.fn = ac_d[`CFT_WORD_W-1];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         exe.valid <= 1'b0;
         ac_q      <= '0;
         flags_q   <= '0;
      end else begin
         if (opr.ready) exe.valid <= opr.valid;
         if (take) begin
            ac_q    <= ac_d;
            flags_q <= flags_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         exe.op      <= opr.op;
         exe.addr    <= opr.addr;
         exe.operand <= (opr.op == cft_pkg::OP_STORE) ? ac_q : '0;  // Store data
      end
   end

endmodule

// File: logic/card_ctl.sv
////////////////////
// Decode card. One word per cycle when downstream keeps up
////////////////////

`include "cft_config.svh"

module card_ctl (
   input  logic            clk,
   input  logic            reset,
   input  logic            in_valid,
   output logic            in_ready,
   input  cft_pkg::instr_t in_instr,
   cft_stage_if.src        dec
);

   cft_pkg::opcode_e       op_d;       // Decoded opcode
   logic [`CFT_ADDR_W-1:0] addr_d;
   logic                   rd_d;
   cft_pkg::word_t         operand_d;  // Extended literal

   assign in_ready  = !dec.valid || dec.ready;  // Empty or draining
   assign dec.ac    = '0;                       // Not produced here
   assign dec.flags = '0;

   always_comb begin
      op_d      = in_instr.mref.op;
      addr_d    = '0;
      rd_d      = 1'b0;
      operand_d = '0;
      case (in_instr.mref.op)
         cft_pkg::OP_LOAD, cft_pkg::OP_ADD, cft_pkg::OP_AND,
         cft_pkg::OP_OR, cft_pkg::OP_XOR: begin
            addr_d = in_instr.mref.addr;  // Reads memory
            rd_d   = 1'b1;
         end
         cft_pkg::OP_STORE: addr_d = in_instr.mref.addr;  // Write target only
         cft_pkg::OP_LI, cft_pkg::OP_ADDI:
            operand_d = cft_pkg::word_t'($signed(in_instr.imm.lit));
         default: op_d = cft_pkg::OP_NOP;  // Codes 8 to 15
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec.valid <= 1'b0;
      end else if (in_ready) begin
         dec.valid <= in_valid;         // Load or drain
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         dec.op      <= op_d;
         dec.addr    <= addr_d;
         dec.rd      <= rd_d;
         dec.operand <= operand_d;
      end
   end

endmodule

// File: logic/card_mem.sv
////////////////////
// Operand card. Memory is not cleared by reset
////////////////////

`include "cft_config.svh"

module card_mem (
   input  logic                   clk,
   input  logic                   reset,
   cft_stage_if.snk               dec,
   cft_stage_if.src               opr,
   input  logic                   mem_we,
   input  logic [`CFT_ADDR_W-1:0] mem_waddr,
   input  cft_pkg::word_t         mem_wdata
);

   cft_pkg::word_t mem [`CFT_MEM_WORDS];  // Data memory
   logic [1:0]     pend_cnt;   // Stores past this card, not yet written
   logic           store_out;  // STORE leaves this card
   logic           rd_block;   // Reads must wait
   logic           take;       // Accept from decode

   assign store_out = opr.valid && opr.ready && (opr.op == cft_pkg::OP_STORE);
   // A STORE still in our own output register counts as in flight too
   assign rd_block  = (pend_cnt != 2'd0) || (opr.valid && (opr.op == cft_pkg::OP_STORE));
   assign dec.ready = (!opr.valid || opr.ready) && !(dec.rd && rd_block);
   assign take      = dec.valid && dec.ready;

   assign opr.rd    = 1'b0;  // Operand already resolved
   assign opr.ac    = '0;
   assign opr.flags = '0;

   ////////////////////
   // Store tracking
   always_ff @(posedge clk) begin
      if (reset) begin
         pend_cnt <= 2'd0;
      end else begin
         case ({store_out, mem_we})
            2'b10:   pend_cnt <= pend_cnt + 2'd1;  // New store in flight
            2'b01:   pend_cnt <= pend_cnt - 2'd1;  // Store landed
            default: pend_cnt <= pend_cnt;         // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_waddr] <= mem_wdata;  // Write port from card_reg
      end
   end

   ////////////////////
   // Operand register
   always_ff @(posedge clk) begin
      if (reset) begin
         opr.valid <= 1'b0;
      end else if (!opr.valid || opr.ready) begin
         opr.valid <= take;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         opr.op      <= dec.op;
         opr.addr    <= dec.addr;
         opr.operand <= dec.rd ? mem[dec.addr] : dec.operand;  // Sync read
      end
   end

endmodule

// File: logic/card_reg.sv
////////////////////
// Result card. The memory write does not wait for out_ready
////////////////////

`include "cft_config.svh"

module card_reg (
   input  logic                   clk,
   input  logic                   reset,
   cft_stage_if.snk               exe,
   output logic                   out_valid,
   input  logic                   out_ready,
   output cft_pkg::word_t         out_ac,
   output cft_pkg::flags_t        out_flags,
   output logic                   mem_we,
   output logic [`CFT_ADDR_W-1:0] mem_waddr,
   output cft_pkg::word_t         mem_wdata
);

   logic take;  // Result accepted this edge

   assign exe.ready = !out_valid || out_ready;
   assign take      = exe.valid && exe.ready;

   ////////////////////
   // Store write port
   assign mem_we    = take && (exe.op == cft_pkg::OP_STORE);  // One cycle
   assign mem_waddr = exe.addr;
   assign mem_wdata = exe.operand;   // Old AC from card_alu

   ////////////////////
   // Output register
   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (exe.ready) begin
         out_valid <= exe.valid;   // Load or drain
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_ac    <= exe.ac;
         out_flags <= exe.flags;
      end
   end

endmodule

// File: logic/cft_config.svh
////////////////////
// Widths shared by every card. Memory depth must equal 2**CFT_ADDR_W
////////////////////

`ifndef CFT_CONFIG_SVH
`define CFT_CONFIG_SVH

`define CFT_WORD_W    16    // Data and instruction word
`define CFT_ADDR_W    10    // Data memory address
`define CFT_MEM_WORDS 1024  // Data memory depth

`endif

// File: logic/cft_pkg.sv
////////////////////
// Opcodes 8 to 15 are not named and decode as NOP
////////////////////

`include "cft_config.svh"

package cft_pkg;

   typedef logic [`CFT_WORD_W-1:0] word_t;  // One machine word

   typedef enum logic [3:0] {
      OP_LOAD  = 4'd0,   // AC = mem
      OP_STORE = 4'd1,   // mem = AC
      OP_ADD   = 4'd2,   // AC += mem
      OP_AND   = 4'd3,
      OP_OR    = 4'd4,
      OP_XOR   = 4'd5,
      OP_LI    = 4'd6,   // AC = literal
      OP_ADDI  = 4'd7,   // AC += literal
      OP_NOP   = 4'd8    // Canonical NOP code
   } opcode_e;

   typedef union packed {
      struct packed {
         opcode_e                op;
         logic [1:0]             rsvd;  // Ignored
         logic [`CFT_ADDR_W-1:0] addr;
      } mref;                           // Memory-reference form
      struct packed {
         opcode_e                op;
         logic signed [11:0]     lit;   // Sign-extended on decode
      } imm;                            // Immediate form
   } instr_t;

   typedef struct packed {
      logic fz;  // Zero
      logic fn;  // Negative
      logic fl;  // Link, carry out of ADD
      logic fv;  // Signed overflow
   } flags_t;

endpackage

// File: logic/cft_stage_if.sv
////////////////////
// One stage-to-stage link. Fields hold while valid waits on ready
////////////////////

`include "cft_config.svh"

interface cft_stage_if;

   logic                   valid;    // Source has an instruction
   logic                   ready;    // Sink can take it
   cft_pkg::opcode_e       op;
   logic [`CFT_ADDR_W-1:0] addr;     // Memory address or store target
   logic                   rd;       // Operand comes from memory
   cft_pkg::word_t         operand;  // Literal, memory word or store data
   cft_pkg::word_t         ac;       // Accumulator after the operation
   cft_pkg::flags_t        flags;

   modport src (
      output valid, op, addr, rd, operand, ac, flags,
      input  ready
   );

   modport snk (
      input  valid, op, addr, rd, operand, ac, flags,
      output ready
   );

endinterface

// File: logic/cft_top.sv
////////////////////
// Backplane. Four cards in a row, one instruction in each
////////////////////

`include "cft_config.svh"

module cft_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  logic [`CFT_WORD_W-1:0] in_instr,
   output logic                   out_valid,
   input  logic                   out_ready,
   output logic [`CFT_WORD_W-1:0] out_ac,
   output logic [3:0]             out_flags   // Z N L V
);

   logic                   mem_we;     // From card_reg to card_mem
   logic [`CFT_ADDR_W-1:0] mem_waddr;
   cft_pkg::word_t         mem_wdata;

   cft_stage_if dec_bus ();  // CTL to MEM
   cft_stage_if opr_bus ();  // MEM to ALU
   cft_stage_if exe_bus ();  // ALU to REG

   ////////////////////
   // Cards
   card_ctl u_ctl (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_instr (in_instr),
      .dec      (dec_bus)
   );

   card_mem u_mem (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec_bus),
      .opr       (opr_bus),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata)
   );

   card_alu u_alu (.clk(clk), .reset(reset), .opr(opr_bus), .exe(exe_bus));

   card_reg u_reg (
      .clk       (clk),
      .reset     (reset),
      .exe       (exe_bus),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_ac    (out_ac),
      .out_flags (out_flags),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata)
   );

endmodule

// File: tb/cft_checker.sv
////////////////////
// Bound into cft_top. Sees the output port and the memory write port
////////////////////

`include "cft_config.svh"

module cft_checker (
   input logic                   clk,
   input logic                   reset,
   input logic                   out_valid,
   input logic                   out_ready,
   input logic [`CFT_WORD_W-1:0] out_ac,
   input logic [3:0]             out_flags,
   input logic                   mem_we,
   input cft_pkg::word_t         mem_wdata
);

   // Result must hold while the consumer stalls
   a_hold: assert property (@(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_ac) && $stable(out_flags)))
      else $error("result changed while out_ready was low");

   a_reset_quiet: assert property (@(posedge clk)
      reset |=> (!out_valid && !mem_we))  // Output and write port idle
      else $error("out_valid or mem_we high during reset");

   // Each write pairs with a result taken by card_reg that reports the stored AC
   a_we_store: assert property (@(posedge clk) disable iff (reset)
      mem_we |=> (out_valid && (out_ac == $past(mem_wdata))))
      else $error("mem_we high without an accepted STORE");

endmodule

bind cft_top cft_checker u_checker (
   .clk       (clk),
   .reset     (reset),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_ac    (out_ac),
   .out_flags (out_flags),
   .mem_we    (mem_we),
   .mem_wdata (mem_wdata)
);

// File: tb/cft_clock.sv
////////////////////
// Free-running clock, period 4
////////////////////

module cft_clock (
   output logic clk
);

   initial clk = 1'b0;
   always #2 clk = ~clk;  // Half period

endmodule

// File: tb/cft_tb.sv
////////////////////
// Reads touch only written addresses, since memory powers up undefined
////////////////////

`include "cft_config.svh"

module cft_tb;

   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_COUNT = 300;

   logic            clk;
   logic            reset;
   logic            in_valid;
   logic            in_ready;
   cft_pkg::instr_t in_instr;
   logic            out_valid;
   logic            out_ready;
   cft_pkg::word_t  out_ac;
   cft_pkg::flags_t out_flags;

   cft_pkg::word_t  m_ac;                      // Model accumulator
   cft_pkg::flags_t m_flags;
   cft_pkg::word_t  m_mem [`CFT_MEM_WORDS];    // Model memory
   cft_pkg::word_t  exp_ac [$];                // Expected results, oldest first
   cft_pkg::flags_t exp_flags [$];
   string           exp_name [$];
   logic [15:0]     lfsr_state = 16'd73;       // Seed
   logic            written [16] = '{default: 1'b0};  // Random pool slots stored
   logic            stall_mode = 1'b0;         // out_ready from LFSR
   int              issued = 0;
   int              results_seen = 0;

   cft_clock u_clock (.clk(clk));

   cft_top uut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_instr  (in_instr),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_ac    (out_ac),
      .out_flags (out_flags)
   );

   ////////////////////
   // Stimulus helpers
   function automatic logic next_random_bit();
      logic lsb;
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
         lfsr_state = lfsr_state ^ 16'hB400;   // Galois taps 16 14 13 11
      end
      return lsb;
   endfunction

   function automatic logic [15:0] random_bits(int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[14:0], next_random_bit()};
      end
      return r;
   endfunction

   function automatic cft_pkg::instr_t mem_instr(logic [3:0] op, logic [9:0] addr);
      return {op, 2'b00, addr};
   endfunction

   function automatic cft_pkg::instr_t imm_instr(logic [3:0] op, logic [11:0] lit);
      return {op, lit};
   endfunction

   function automatic cft_pkg::instr_t random_instr();
      logic [15:0] r;
      logic [3:0]  op;
      logic [3:0]  slot;
      r    = random_bits(3);
      op   = {1'b0, r[2:0]};
      r    = random_bits(4);
      slot = r[3:0];
      r    = random_bits(4);
      if (r[3:0] == 4'hF) begin
         op = {1'b1, op[2:0]};                 // Now and then a NOP code
      end
      if ((op inside {4'd0, 4'd2, 4'd3, 4'd4, 4'd5}) && !written[slot]) begin
         op = 4'd1;                            // Store before first read
      end
      if (op == 4'd1) begin
         written[slot] = 1'b1;
      end
      if (op == 4'd6 || op == 4'd7) begin
         r = random_bits(12);
         return imm_instr(op, r[11:0]);
      end
      return mem_instr(op, {slot, 6'h15});     // 16 spread addresses
   endfunction

   ////////////////////
   // Reference model
   function automatic void cft_model(cft_pkg::instr_t ins, string name);
      logic [3:0]     code;
      cft_pkg::word_t opnd;
      int             u_sum;
      int             s_sum;
      code = ins.mref.op;
      opnd = m_mem[ins.mref.addr];
      if (code == 4'd6 || code == 4'd7) begin
         opnd = {{4{ins.imm.lit[11]}}, ins.imm.lit};   // Signed literal
      end
      case (code)
         4'd0, 4'd6: m_ac = opnd;                      // LOAD, LI
         4'd1:       m_mem[ins.mref.addr] = m_ac;      // STORE keeps AC
         4'd2, 4'd7: begin
            u_sum      = int'(m_ac) + int'(opnd);
            s_sum      = int'($signed(m_ac)) + int'($signed(opnd));
            m_ac       = u_sum[15:0];
            m_flags.fl = u_sum[16];                    // Carry out
            m_flags.fv = (s_sum > 32767) || (s_sum < -32768);
         end
         4'd3:       m_ac = m_ac & opnd;
         4'd4:       m_ac = m_ac | opnd;
         4'd5:       m_ac = m_ac ^ opnd;
         default:    ;                                 // Codes 8 to 15
      endcase
      m_flags.fz = (m_ac == 16'h0000);
      m_flags.fn = m_ac[15];
      exp_ac.push_back(m_ac);
      exp_flags.push_back(m_flags);
      exp_name.push_back(name);
   endfunction

   ////////////////////
   // Compare tasks
   task automatic check_word(string name, cft_pkg::word_t exp, cft_pkg::word_t act);
      if (act !== exp) begin
         $display("error %s: AC expected %h, actual %h", name, exp, act);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_flags(string name, cft_pkg::flags_t exp, cft_pkg::flags_t act);
      if (act !== exp) begin
         $display("error %s: flags ZNLV expected %b, actual %b", name, exp, act);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("error %s: expected %b, actual %b", name, exp, act);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // Handshake seen mid-cycle, completes on the next rising edge
   always @(negedge clk) begin
      string name;
      if (!reset && out_valid && out_ready) begin
         if (exp_ac.size() == 0) begin
            $display("A result arrived with no instruction left to account for it");
            $display("Verification failed");
            $fatal(1, "unexpected result");
         end else begin
            name = exp_name.pop_front();
            check_word(name, exp_ac.pop_front(), out_ac);
            check_flags(name, exp_flags.pop_front(), out_flags);
            results_seen++;
         end
      end
   end

   // Budget grows with each issued instruction
   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > RESET_CYCLES + 20 * (issued + 1)) begin
            $display("Timeout: results stopped arriving after %0d instructions", issued);
            $display("Verification failed");
            $fatal(1, "watchdog expired");
         end
      end
   end

   ////////////////////
   // Drive and sequence
   task automatic advance();
      logic [15:0] r;
      @(posedge clk);
      #1;
      out_ready = 1'b1;
      if (stall_mode) begin
         r         = random_bits(2);
         out_ready = (r[1:0] != 2'b00);        // Ready 3 cycles in 4
      end
   endtask

   task automatic issue(cft_pkg::instr_t ins, string name);
      logic taken;
      taken    = 1'b0;
      in_valid = 1'b1;
      in_instr = ins;
      while (!taken) begin
         @(negedge clk);
         taken = in_ready;                      // Stable until the edge
         advance();
      end
      cft_model(ins, name);
      issued++;
      in_valid = 1'b0;
   endtask

   initial begin
      reset     = 1'b1;
      in_valid  = 1'b0;
      in_instr  = '0;
      out_ready = 1'b1;
      m_ac      = '0;
      m_flags   = '0;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_bit("reset out_valid", 1'b0, out_valid);
      check_bit("reset in_ready", 1'b1, in_ready);
      @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit("first cycle out_valid", 1'b0, out_valid);
      check_bit("first cycle in_ready", 1'b1, in_ready);
      advance();

      issue(imm_instr(cft_pkg::OP_LI, 12'h123), "li positive");
      issue(imm_instr(cft_pkg::OP_LI, 12'hFFB), "li negative");
      issue(imm_instr(cft_pkg::OP_ADDI, 12'h005), "addi carry to zero");
      issue(imm_instr(cft_pkg::OP_LI, 12'h800), "li most negative");
      repeat (15) issue(imm_instr(cft_pkg::OP_ADDI, 12'h800), "addi walk down");
      issue(imm_instr(cft_pkg::OP_ADDI, 12'hFFF), "addi overflow down");
      issue(imm_instr(cft_pkg::OP_ADDI, 12'h001), "addi overflow up");
      issue(imm_instr(cft_pkg::OP_ADDI, 12'h7FF), "addi negative");

      issue(imm_instr(cft_pkg::OP_LI, 12'h123), "mem setup");
      issue(mem_instr(cft_pkg::OP_STORE, 10'h010), "store 010");
      issue(mem_instr(cft_pkg::OP_LOAD, 10'h010), "load after store");  // Interlock
      issue(imm_instr(cft_pkg::OP_LI, 12'hFFB), "mem setup");
      issue(mem_instr(cft_pkg::OP_STORE, 10'h155), "store 155");
      issue(imm_instr(cft_pkg::OP_LI, 12'h7F0), "mem setup");
      issue(mem_instr(cft_pkg::OP_STORE, 10'h3FF), "store 3ff");
      issue(imm_instr(cft_pkg::OP_LI, 12'h000), "mem clear");
      issue(mem_instr(cft_pkg::OP_LOAD, 10'h155), "load 155");
      issue(mem_instr(cft_pkg::OP_ADD, 10'h010), "add 010");
      issue(mem_instr(cft_pkg::OP_AND, 10'h3FF), "and 3ff");
      issue(mem_instr(cft_pkg::OP_OR, 10'h010), "or 010");
      issue(mem_instr(cft_pkg::OP_XOR, 10'h155), "xor 155");
      issue(mem_instr(cft_pkg::OP_STORE, 10'h200), "store 200");
      issue(mem_instr(cft_pkg::OP_LOAD, 10'h200), "load 200");

      issue(imm_instr(4'd8, 12'h000), "nop code 8");
      issue(imm_instr(4'd15, 12'hFFF), "nop code 15");
      issue(mem_instr(4'd11, 10'h155), "nop code 11");

      stall_mode = 1'b1;
      for (int i = 0; i < RANDOM_COUNT; i++) begin
         issue(random_instr(), "random stream");
      end
      stall_mode = 1'b0;
      while (exp_ac.size() != 0) begin
         advance();
      end
      repeat (8) advance();                     // Room for a stray result

      if (exp_ac.size() == 0 && results_seen == issued) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Got %0d results for %0d instructions", results_seen, issued);
         $display("Verification failed");
         $fatal(1, "result count mismatch");
      end
   end

endmodule
